// File: hw/kitchen_pkg.sv
package kitchen_pkg;

    // kitchen grid geometry.
    localparam int GRID_COLS  = 13;
    localparam int GRID_ROWS  = 8;
    localparam int CELL_SHIFT = 5;     // 32 pixel cells.

    localparam int STOVE_ROW  = 0;
    localparam int STOVE_COL0 = 8;     // stoves sit in columns 8 to 11.
    localparam int SERVE_ROW  = 7;
    localparam int SERVE_COL  = 6;

    // frame counts, the clock runs once per frame.
    localparam int CHOP_FRAMES       = 8;
    localparam int COOK_FRAMES       = 20;
    localparam int BURN_FRAMES       = 20;
    localparam int FRAMES_PER_SECOND = 60;
    localparam int ROUND_SECONDS     = 150;

    // host register map.
    localparam logic [11:0] STATUS_ADDR = 12'h400;
    localparam logic [11:0] CTRL_ADDR   = 12'h404;

    typedef enum logic [3:0] {
        G_EMPTY         = 4'd0,
        G_ONION_WHOLE   = 4'd1,
        G_ONION_CHOPPED = 4'd2,
        G_BOWL_EMPTY    = 4'd3,
        G_BOWL_FULL     = 4'd4,
        G_POT_EMPTY     = 4'd5,
        G_POT_RAW       = 4'd6,
        G_POT_COOKED    = 4'd7,
        G_POT_FIRE      = 4'd8,
        G_FIRE          = 4'd9,
        G_EXTINGUISHER  = 4'd10,
        G_SERVE         = 4'd11
    } obj_t;

    typedef enum logic [3:0] {
        P_NOTHING       = 4'd0,
        P_CHOPPING      = 4'd1,
        P_ONION_WHOLE   = 4'd2,
        P_ONION_CHOPPED = 4'd3,
        P_POT_EMPTY     = 4'd4,
        P_POT_RAW       = 4'd5,
        P_POT_COOKED    = 4'd6,
        P_BOWL_EMPTY    = 4'd7,
        P_BOWL_FULL     = 4'd8,
        P_EXT_OFF       = 4'd9,
        P_EXT_ON        = 4'd10
    } pstate_t;

    typedef enum logic [1:0] {
        DIR_LEFT  = 2'd0,
        DIR_RIGHT = 2'd1,
        DIR_UP    = 2'd2,
        DIR_DOWN  = 2'd3
    } dir_t;

    typedef enum logic [2:0] {
        GS_WELCOME = 3'd0,
        GS_START   = 3'd1,
        GS_PLAY    = 3'd2,
        GS_PAUSE   = 3'd3,
        GS_FINISH  = 3'd4
    } game_state_t;

endpackage

// File: hw/front_cell.sv
`timescale 1ns/1ps

module front_cell
    import kitchen_pkg::*;
(
    input  logic [8:0] player_loc_x,
    input  logic [8:0] player_loc_y,
    input  dir_t       player_direction,
    input  obj_t       lookup_obj,
    output logic       front_valid,
    output logic [2:0] front_row,
    output logic [3:0] front_col,
    output obj_t       front_obj
);

    logic [9:0] px, py;
    logic [4:0] cx, cy;
    logic [5:0] fx, fy;   // extra bit so a step left of column 0 wraps out of range.

    // sprite centre, then the cell it falls in.
    assign px = {1'b0, player_loc_x} + 10'd16;
    assign py = {1'b0, player_loc_y} + 10'd16;
    assign cx = 5'(px >> CELL_SHIFT);
    assign cy = 5'(py >> CELL_SHIFT);

    always_comb begin
        fx = {1'b0, cx};
        fy = {1'b0, cy};
        case (player_direction)
            DIR_LEFT:  fx = {1'b0, cx} - 6'd1;
            DIR_RIGHT: fx = {1'b0, cx} + 6'd1;
            DIR_UP:    fy = {1'b0, cy} - 6'd1;
            default:   fy = {1'b0, cy} + 6'd1;
        endcase
    end

    assign front_valid = (fx < 6'(GRID_COLS)) && (fy < 6'(GRID_ROWS));
    assign front_col   = fx[3:0];
    assign front_row   = fy[2:0];
    assign front_obj   = front_valid ? lookup_obj : G_EMPTY;  // off-grid looks like a wall.

endmodule

// File: hw/action_fsm.sv
`timescale 1ns/1ps

module action_fsm
    import kitchen_pkg::*;
(
    input  logic       vsync,
    input  logic       reset,
    input  logic       round_active,
    input  logic       chop,
    input  logic       carry,
    input  logic       front_valid,
    input  logic [2:0] front_row,
    input  logic [3:0] front_col,
    input  obj_t       front_obj,
    output pstate_t    player_state,
    output logic       act_we,
    output logic [2:0] act_row,
    output logic [3:0] act_col,
    output obj_t       act_obj,
    output logic       serve_pulse
);

    pstate_t    next_state;
    logic [3:0] chop_cnt;

    // what the player ends up holding after picking an object up.
    function automatic pstate_t pick_state(obj_t obj);
        case (obj)
            G_ONION_WHOLE:   return P_ONION_WHOLE;
            G_ONION_CHOPPED: return P_ONION_CHOPPED;
            G_POT_EMPTY:     return P_POT_EMPTY;
            G_POT_RAW:       return P_POT_RAW;
            G_POT_COOKED:    return P_POT_COOKED;
            G_BOWL_EMPTY:    return P_BOWL_EMPTY;
            G_BOWL_FULL:     return P_BOWL_FULL;
            default:         return P_NOTHING;
        endcase
    endfunction

    function automatic obj_t held_obj(pstate_t st);
        case (st)
            P_ONION_WHOLE:   return G_ONION_WHOLE;
            P_ONION_CHOPPED: return G_ONION_CHOPPED;
            P_POT_EMPTY:     return G_POT_EMPTY;
            P_POT_RAW:       return G_POT_RAW;
            P_POT_COOKED:    return G_POT_COOKED;
            P_BOWL_EMPTY:    return G_BOWL_EMPTY;
            P_BOWL_FULL:     return G_BOWL_FULL;
            default:         return G_EMPTY;
        endcase
    endfunction

    // at most one grid write per frame, always to the front cell.
    always_comb begin
        next_state  = player_state;
        act_we      = 1'b0;
        act_row     = front_row;
        act_col     = front_col;
        act_obj     = G_EMPTY;
        serve_pulse = 1'b0;
        if (round_active) begin
            case (player_state)
                P_NOTHING: begin
                    if (chop && front_obj == G_ONION_WHOLE) begin
                        next_state = P_CHOPPING;
                    end else if (carry && pick_state(front_obj) != P_NOTHING) begin
                        next_state = pick_state(front_obj);
                        act_we     = 1'b1;   // lifted off the counter.
                    end
                end
                P_CHOPPING: begin
                    if (!chop || front_obj != G_ONION_WHOLE) begin
                        next_state = P_NOTHING;   // let go early, onion untouched.
                    end else if (chop_cnt == 4'(CHOP_FRAMES - 1)) begin
                        next_state = P_NOTHING;
                        act_we     = 1'b1;
                        act_obj    = G_ONION_CHOPPED;
                    end
                end
                default: begin
                    if (!carry) begin
                        if (front_valid && front_obj == G_EMPTY) begin
                            next_state = P_NOTHING;
                            act_we     = 1'b1;
                            act_obj    = held_obj(player_state);
                        end else if (player_state == P_ONION_CHOPPED &&
                                     front_obj == G_POT_EMPTY) begin
                            next_state = P_NOTHING;
                            act_we     = 1'b1;
                            act_obj    = G_POT_RAW;
                        end else if (player_state == P_POT_COOKED &&
                                     front_obj == G_BOWL_EMPTY) begin
                            next_state = P_POT_EMPTY;   // soup poured, pot stays in hand.
                            act_we     = 1'b1;
                            act_obj    = G_BOWL_FULL;
                        end else if (player_state == P_BOWL_FULL && front_obj == G_SERVE) begin
                            next_state  = P_NOTHING;
                            serve_pulse = 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge vsync) begin
        if (reset) begin
            player_state <= P_NOTHING;
            chop_cnt     <= '0;
        end else begin
            player_state <= next_state;
            if (next_state != P_CHOPPING)
                chop_cnt <= '0;
            else if (player_state != P_CHOPPING)
                chop_cnt <= 4'd1;   // the frame that starts the chop counts.
            else if (round_active)
                chop_cnt <= chop_cnt + 4'd1;
        end
    end

endmodule

// File: hw/stove_timers.sv
`timescale 1ns/1ps

module stove_timers
    import kitchen_pkg::*;
(
    input  logic           vsync,
    input  logic           reset,
    input  obj_t [3:0]     stove_obj_in,
    output logic [3:0]     stove_we,
    output obj_t [3:0]     stove_obj
);

    logic [4:0] cnt [4];
    logic [3:0] heating;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            heating[i]   = (stove_obj_in[i] == G_POT_RAW) || (stove_obj_in[i] == G_POT_COOKED);
            stove_we[i]  = 1'b0;
            stove_obj[i] = stove_obj_in[i];
            if (stove_obj_in[i] == G_POT_RAW && cnt[i] == 5'(COOK_FRAMES - 1)) begin
                stove_we[i]  = 1'b1;
                stove_obj[i] = G_POT_COOKED;
            end else if (stove_obj_in[i] == G_POT_COOKED && cnt[i] == 5'(BURN_FRAMES - 1)) begin
                stove_we[i]  = 1'b1;
                stove_obj[i] = G_POT_FIRE;
            end
        end
    end

    // counter restarts on every change of the pot, so burn time starts at cooked.
    always_ff @(posedge vsync) begin
        if (reset) begin
            for (int i = 0; i < 4; i++)
                cnt[i] <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (stove_we[i] || !heating[i])
                    cnt[i] <= '0;
                else
                    cnt[i] <= cnt[i] + 5'd1;
            end
        end
    end

endmodule

// File: hw/round_timer.sv
`timescale 1ns/1ps

module round_timer
    import kitchen_pkg::*;
#(
    parameter int GIVEN_TIME = ROUND_SECONDS
) (
    input  logic        vsync,
    input  logic        reset,
    input  logic        restart,
    input  game_state_t game_state,
    output logic [7:0]  time_left,
    output logic        round_active
);

    logic [5:0] frame_cnt;   // frames within the current second.

    assign round_active = (game_state == GS_PLAY) && (time_left != 8'd0);

    always_ff @(posedge vsync) begin
        if (reset || restart) begin
            frame_cnt <= '0;
            time_left <= 8'(GIVEN_TIME);
        end else if (round_active) begin
            if (frame_cnt == 6'(FRAMES_PER_SECOND - 1)) begin
                frame_cnt <= '0;
                time_left <= time_left - 8'd1;
            end else begin
                frame_cnt <= frame_cnt + 6'd1;
            end
        end
    end

endmodule

// File: hw/kitchen_grid.sv
`timescale 1ns/1ps

module kitchen_grid
    import kitchen_pkg::*;
(
    input  logic       vsync,
    input  logic       reset,
    input  logic       act_we,
    input  logic [2:0] act_row,
    input  logic [3:0] act_col,
    input  obj_t       act_obj,
    input  logic [3:0] stove_we,
    input  obj_t [3:0] stove_obj,
    input  logic [2:0] lookup_row,
    input  logic [3:0] lookup_col,
    input  logic [2:0] read_row,
    input  logic [3:0] read_col,
    output obj_t       lookup_obj,
    output obj_t       read_obj,
    output obj_t [3:0] stove_obj_in
);

    obj_t       grid [GRID_ROWS][GRID_COLS];
    logic [3:0] stove_keep;

    // player write takes the cell, the stove request for it is dropped.
    always_comb begin
        for (int i = 0; i < 4; i++)
            stove_keep[i] = stove_we[i] &&
                            !(act_we && act_row == 3'(STOVE_ROW) && act_col == 4'(STOVE_COL0 + i));
    end

    always_ff @(posedge vsync) begin
        if (reset) begin
            for (int r = 0; r < GRID_ROWS; r++)
                for (int c = 0; c < GRID_COLS; c++)
                    grid[r][c] <= G_EMPTY;
            grid[2][0]  <= G_ONION_WHOLE;
            grid[3][0]  <= G_ONION_WHOLE;
            grid[6][12] <= G_BOWL_EMPTY;
            for (int i = 0; i < 4; i++)
                grid[STOVE_ROW][STOVE_COL0+i] <= G_POT_EMPTY;
            grid[SERVE_ROW][SERVE_COL] <= G_SERVE;
        end else begin
            for (int i = 0; i < 4; i++)
                if (stove_keep[i])
                    grid[STOVE_ROW][STOVE_COL0+i] <= stove_obj[i];
            if (act_we)
                grid[act_row][act_col] <= act_obj;
        end
    end

    assign lookup_obj = (lookup_col < 4'(GRID_COLS)) ? grid[lookup_row][lookup_col] : G_EMPTY;
    assign read_obj   = (read_col < 4'(GRID_COLS)) ? grid[read_row][read_col] : G_EMPTY;

    always_comb begin
        for (int i = 0; i < 4; i++)
            stove_obj_in[i] = grid[STOVE_ROW][STOVE_COL0+i];
    end

endmodule

// File: hw/apb_status.sv
`timescale 1ns/1ps

module apb_status
    import kitchen_pkg::*;
(
    input  logic        vsync,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    input  obj_t        read_obj,
    input  pstate_t     player_state,
    input  logic [7:0]  time_left,
    input  logic [7:0]  orders_served,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [2:0]  read_row,
    output logic [3:0]  read_col,
    output logic        restart
);

    logic setup, cell_sel, cell_ok, status_sel, ctrl_sel;

    assign setup      = psel && !penable;
    assign read_row   = paddr[8:6];   // cell address is (row*16 + col)*4.
    assign read_col   = paddr[5:2];
    assign cell_sel   = (paddr[11:9] == 3'd0);
    assign cell_ok    = cell_sel && (read_col < 4'(GRID_COLS));
    assign status_sel = (paddr == STATUS_ADDR);
    assign ctrl_sel   = (paddr == CTRL_ADDR);

    // response is captured in setup so it is valid for the whole access phase.
    always_ff @(posedge vsync) begin
        if (reset) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            restart <= 1'b0;
        end else begin
            pready  <= setup;
            pslverr <= setup && !(cell_ok || status_sel || ctrl_sel);
            restart <= psel && penable && pwrite && ctrl_sel && pwdata[0];
        end
    end

    always_ff @(posedge vsync) begin
        if (setup && !pwrite) begin
            if (cell_ok)
                prdata <= {28'd0, read_obj};
            else if (status_sel)
                prdata <= {8'd0, orders_served, time_left, 4'd0, player_state};
            else
                prdata <= '0;
        end
    end

endmodule

// File: hw/kitchen_top.sv
`timescale 1ns/1ps

module kitchen_top
    import kitchen_pkg::*;
(
    input  logic        vsync,
    input  logic        reset,
    input  game_state_t game_state,
    input  dir_t        player_direction,
    input  logic [8:0]  player_loc_x,
    input  logic [8:0]  player_loc_y,
    input  logic        chop,
    input  logic        carry,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output pstate_t     player_state
);

    logic       front_valid, act_we, serve_pulse, round_active, restart;
    logic [2:0] front_row, act_row, read_row;
    logic [3:0] front_col, act_col, read_col, stove_we;
    logic [7:0] time_left, orders_served;
    obj_t       lookup_obj, front_obj, act_obj, read_obj;
    obj_t [3:0] stove_obj, stove_obj_in;

    front_cell u_front (.player_loc_x, .player_loc_y, .player_direction, .lookup_obj,
                        .front_valid, .front_row, .front_col, .front_obj);

    action_fsm u_action (.vsync, .reset, .round_active, .chop, .carry, .front_valid,
                         .front_row, .front_col, .front_obj, .player_state, .act_we,
                         .act_row, .act_col, .act_obj, .serve_pulse);

    stove_timers u_stove (.vsync, .reset, .stove_obj_in, .stove_we, .stove_obj);

    round_timer #(.GIVEN_TIME(ROUND_SECONDS)) u_timer (.vsync, .reset, .restart, .game_state,
                                                       .time_left, .round_active);

    kitchen_grid u_grid (.vsync, .reset, .act_we, .act_row, .act_col, .act_obj, .stove_we,
                         .stove_obj, .lookup_row(front_row), .lookup_col(front_col),
                         .read_row, .read_col, .lookup_obj, .read_obj, .stove_obj_in);

    apb_status u_apb (.vsync, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .read_obj,
                      .player_state, .time_left, .orders_served, .prdata, .pready, .pslverr,
                      .read_row, .read_col, .restart);

    always_ff @(posedge vsync) begin
        if (reset || restart)
            orders_served <= '0;
        else if (serve_pulse)
            orders_served <= orders_served + 8'd1;   // one per bowl delivered.
    end

endmodule

// File: tb/tb_kitchen.sv
`timescale 1ns/1ps

module tb_kitchen
    import kitchen_pkg::*;
();

    logic        vsync;
    logic        reset;
    game_state_t game_state;
    dir_t        player_direction;
    logic [8:0]  player_loc_x;
    logic [8:0]  player_loc_y;
    logic        chop;
    logic        carry;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    pstate_t     player_state;

    integer seed = 50;
    int     errors = 0;
    int     err_mark = 0;
    int     test_num = 0;
    int     tests_failed = 0;
    int     onion_row;
    int     stove_col;
    obj_t   stove_cell;

    kitchen_top uut (.*);

    always #50 vsync = ~vsync;

    // the stove under test, watched for exact cook and burn edges.
    assign stove_cell = uut.u_grid.grid[STOVE_ROW][stove_col];

    a_ready_access: assert property (@(posedge vsync) disable iff (reset)
        pready |-> (psel && penable))
        else begin
            errors++;
            $display("pready was high outside an APB access phase at %0t", $time);
        end

    a_err_with_ready: assert property (@(posedge vsync) disable iff (reset)
        pslverr |-> pready)
        else begin
            errors++;
            $display("pslverr was high without pready at %0t", $time);
        end

    a_frozen_outside_play: assert property (@(posedge vsync) disable iff (reset)
        (game_state != GS_PLAY) |=> $stable(player_state))
        else begin
            errors++;
            $display("player state changed while the game was not in play at %0t", $time);
        end

    // reset layout of the grid.
    function automatic obj_t layout_obj(input int row, input int col);
        if (row == STOVE_ROW && col >= STOVE_COL0 && col <= STOVE_COL0 + 3)
            return G_POT_EMPTY;
        if (col == 0 && (row == 2 || row == 3))
            return G_ONION_WHOLE;
        if (row == 6 && col == 12)
            return G_BOWL_EMPTY;
        if (row == SERVE_ROW && col == SERVE_COL)
            return G_SERVE;
        return G_EMPTY;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected)
            else begin
                errors++;
                $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            end
    endtask

    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] data,
                              output logic err);
        int n;
        @(posedge vsync);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge vsync);
        penable <= 1'b1;
        n = 0;
        @(negedge vsync);
        while (!pready && n < 8) begin
            @(negedge vsync);
            n++;
        end
        if (!pready) begin
            errors++;
            $display("no pready from the DUT for address %h", addr);
        end
        data = prdata;
        err  = pslverr;
        @(posedge vsync);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic check_cell(input int row, input int col, input obj_t want);
        logic [31:0] data;
        logic        err;
        apb_access(1'b0, 12'((row * 16 + col) * 4), 32'd0, data, err);
        check_value($sformatf("cell[%0d][%0d]", row, col), want, data);
        check_value($sformatf("pslverr cell[%0d][%0d]", row, col), 0, err);
    endtask

    task automatic read_status(output logic [3:0] st, output logic [7:0] tl,
                               output logic [7:0] os);
        logic [31:0] data;
        logic        err;
        apb_access(1'b0, STATUS_ADDR, 32'd0, data, err);
        check_value("pslverr status", 0, err);
        st = data[3:0];
        tl = data[15:8];
        os = data[23:16];
    endtask

    // poll one cell through the host port.
    task automatic wait_cell(input int row, input int col, input obj_t want, input int limit);
        logic [31:0] data;
        logic        err;
        int          n;
        n    = 0;
        data = '1;
        while (data != want && n < limit) begin
            apb_access(1'b0, 12'((row * 16 + col) * 4), 32'd0, data, err);
            n++;
        end
        if (data != want) begin
            errors++;
            $display("cell[%0d][%0d] never reached object code %0d", row, col, want);
        end
    endtask

    task automatic place_player(input int col, input int row, input dir_t dir,
                                input logic do_chop, input logic do_carry);
        @(posedge vsync);
        player_loc_x     <= 9'(col << CELL_SHIFT);
        player_loc_y     <= 9'(row << CELL_SHIFT);
        player_direction <= dir;
        chop             <= do_chop;
        carry            <= do_carry;
    endtask

    // chop is sampled high on exactly the given number of edges.
    task automatic hold_chop(input int frames);
        @(posedge vsync);
        chop <= 1'b1;
        repeat (frames - 1) @(posedge vsync);
        @(posedge vsync);
        chop <= 1'b0;
    endtask

    task automatic wait_state(input pstate_t want, input int limit);
        int n;
        n = 0;
        @(negedge vsync);
        while (player_state != want && n < limit) begin
            @(negedge vsync);
            n++;
        end
        if (player_state != want) begin
            errors++;
            $display("player never reached state %0d, stuck in %0d", want, player_state);
        end
    endtask

    task automatic count_frames(input obj_t want, input int limit, output int n);
        n = 0;
        while (stove_cell != want && n < limit) begin
            @(negedge vsync);
            n++;
        end
        if (stove_cell != want) begin
            errors++;
            $display("stove cell never reached object code %0d", want);
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == err_mark) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", test_num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        logic [3:0]  st;
        logic [7:0]  tl;
        logic [7:0]  tl_next;
        logic [7:0]  os;
        logic [7:0]  os_start;
        int          n;
        int          other_row;
        int          stove2;

        vsync            = 1'b0;
        reset            = 1'b1;
        game_state       = GS_WELCOME;
        player_direction = DIR_DOWN;
        player_loc_x     = 9'(5 << CELL_SHIFT);
        player_loc_y     = 9'(4 << CELL_SHIFT);
        chop             = 1'b0;
        carry            = 1'b0;
        psel             = 1'b0;
        penable          = 1'b0;
        pwrite           = 1'b0;
        paddr            = '0;
        pwdata           = '0;

        onion_row = 2 + ($random(seed) & 1);
        stove_col = STOVE_COL0 + ($random(seed) & 3);
        other_row = 5 - onion_row;
        stove2    = STOVE_COL0 + ((stove_col - STOVE_COL0 + 1) % 4);

        repeat (16) @(posedge vsync);
        reset <= 1'b0;

        @(negedge vsync);
        check_value("pready", 0, pready);
        check_value("pslverr", 0, pslverr);
        check_value("player_state", P_NOTHING, player_state);
        for (int r = 0; r < GRID_ROWS; r++)
            for (int c = 0; c < GRID_COLS; c++)
                check_cell(r, c, layout_obj(r, c));
        read_status(st, tl, os);
        check_value("status player_state", P_NOTHING, st);
        check_value("status time_left", ROUND_SECONDS, tl);
        check_value("status orders_served", 0, os);
        apb_access(1'b0, 12'(13 * 4), 32'd0, data, err);   // column 13 is off the grid.
        check_value("pslverr column 13", 1, err);
        check_value("prdata column 13", 0, data);
        apb_access(1'b0, 12'h408, 32'd0, data, err);
        check_value("pslverr address 408", 1, err);
        end_test("reset layout");

        @(posedge vsync) game_state <= GS_PLAY;
        place_player(1, onion_row, DIR_LEFT, 1'b0, 1'b1);
        wait_state(P_ONION_WHOLE, 10);
        check_cell(onion_row, 0, G_EMPTY);
        place_player(2, 5, DIR_LEFT, 1'b0, 1'b1);
        place_player(2, 5, DIR_LEFT, 1'b0, 1'b0);   // drop onto row 5 col 1.
        wait_state(P_NOTHING, 10);
        check_cell(5, 1, G_ONION_WHOLE);
        read_status(st, tl, os);
        check_value("status player_state", P_NOTHING, st);
        end_test("pick and place");

        hold_chop(CHOP_FRAMES - 1);   // one frame short.
        wait_state(P_NOTHING, 10);
        check_cell(5, 1, G_ONION_WHOLE);
        hold_chop(CHOP_FRAMES);
        wait_state(P_NOTHING, 10);
        check_cell(5, 1, G_ONION_CHOPPED);
        end_test("chop");

        place_player(2, 5, DIR_LEFT, 1'b0, 1'b1);
        wait_state(P_ONION_CHOPPED, 10);
        place_player(stove_col, 1, DIR_UP, 1'b0, 1'b1);
        place_player(stove_col, 1, DIR_UP, 1'b0, 1'b0);
        wait_state(P_NOTHING, 10);
        check_value("stove cell", G_POT_RAW, stove_cell);
        count_frames(G_POT_COOKED, 2 * COOK_FRAMES, n);
        check_value("cook frames", COOK_FRAMES, n);
        count_frames(G_POT_FIRE, 2 * BURN_FRAMES, n);
        check_value("burn frames", BURN_FRAMES, n);
        check_cell(STOVE_ROW, stove_col, G_POT_FIRE);
        end_test("cook");

        read_status(st, tl, os_start);
        place_player(1, other_row, DIR_LEFT, 1'b0, 1'b0);
        hold_chop(CHOP_FRAMES);
        wait_state(P_NOTHING, 10);
        place_player(1, other_row, DIR_LEFT, 1'b0, 1'b1);
        wait_state(P_ONION_CHOPPED, 10);
        place_player(stove2, 1, DIR_UP, 1'b0, 1'b1);
        place_player(stove2, 1, DIR_UP, 1'b0, 1'b0);
        wait_state(P_NOTHING, 10);
        wait_cell(STOVE_ROW, stove2, G_POT_COOKED, 20);
        place_player(stove2, 1, DIR_UP, 1'b0, 1'b1);
        wait_state(P_POT_COOKED, 10);
        place_player(11, 6, DIR_RIGHT, 1'b0, 1'b1);   // facing the bowl.
        place_player(11, 6, DIR_RIGHT, 1'b0, 1'b0);
        wait_state(P_POT_EMPTY, 10);
        check_cell(6, 12, G_BOWL_FULL);
        read_status(st, tl, os);
        check_value("status player_state", P_POT_EMPTY, st);
        place_player(11, 5, DIR_DOWN, 1'b0, 1'b0);   // empty pot set down at row 6 col 11.
        wait_state(P_NOTHING, 10);
        place_player(11, 6, DIR_RIGHT, 1'b0, 1'b1);
        wait_state(P_BOWL_FULL, 10);
        place_player(SERVE_COL, SERVE_ROW - 1, DIR_DOWN, 1'b0, 1'b1);
        place_player(SERVE_COL, SERVE_ROW - 1, DIR_DOWN, 1'b0, 1'b0);
        wait_state(P_NOTHING, 10);
        read_status(st, tl, os);
        check_value("status orders_served", os_start + 1, os);
        check_value("status player_state", P_NOTHING, st);
        end_test("serve");

        // the second read starts FRAMES_PER_SECOND edges after the first.
        read_status(st, tl, os);
        repeat (FRAMES_PER_SECOND - 3) @(posedge vsync);
        read_status(st, tl_next, os);
        check_value("time_left after one second", tl - 1, tl_next);
        @(posedge vsync) game_state <= GS_PAUSE;
        place_player(11, 5, DIR_DOWN, 1'b0, 1'b1);   // pot in front, carry ignored.
        read_status(st, tl, os);
        repeat (2 * FRAMES_PER_SECOND) @(posedge vsync);
        read_status(st, tl_next, os);
        check_value("time_left in pause", tl, tl_next);
        check_value("status player_state", P_NOTHING, st);
        check_cell(6, 11, G_POT_EMPTY);
        apb_access(1'b1, CTRL_ADDR, 32'h1, data, err);
        check_value("pslverr control write", 0, err);
        read_status(st, tl, os);
        check_value("time_left after restart", ROUND_SECONDS, tl);
        check_value("orders_served after restart", 0, os);
        place_player(11, 5, DIR_DOWN, 1'b0, 1'b0);
        end_test("round");

        $display("%0d tests, %0d passed, %0d failed, %0d errors", test_num,
                 test_num - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: verilog.f
hw/kitchen_pkg.sv
hw/front_cell.sv
hw/action_fsm.sv
hw/stove_timers.sv
hw/round_timer.sv
hw/kitchen_grid.sv
hw/apb_status.sv
hw/kitchen_top.sv
tb/tb_kitchen.sv
